//--- sources.f
src/cache_types_pkg.sv
src/wb_bus_pkg.sv
src/lookup_decode.sv
src/evict_buffer.sv
src/lookup_result.sv
src/line_drain.sv
src/write_buffer_top.sv
sim/wb_mem_model.sv
sim/tb_write_buffer.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_write_buffer
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Test completed successfully" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- sim/tb_write_buffer.sv
module tb_write_buffer
    import cache_types_pkg::*;
    import wb_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int TIMEOUT = 2000; // cycles per wait loop.

    logic clk, rst, stall, hold_ack;
    logic victim_valid, full, empty;
    logic [ADDR_W-1:0] victim_addr;
    logic [LINE_W-1:0] victim_line;
    logic lk_valid, lk_we, lk_hit;
    logic [ADDR_W-1:0] lk_addr;
    logic [WB_SEL_W-1:0] lk_sel;
    logic [WB_DAT_W-1:0] lk_wdata, lk_rdata;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [ADDR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat;
    logic [WB_SEL_W-1:0] wb_sel;

    logic [15:0] lfsr = 16'd946;
    int errors = 0;
    int mark = 0;
    int passed = 0;
    int failed = 0;
    logic [ADDR_W-1:0] sb_addr [$]; // queued lines, oldest first.
    logic [LINE_W-1:0] sb_line [$];
    logic inflight;                 // sb_addr[0] is being drained.
    logic [WB_DAT_W-1:0] exp_mem [1024];

    write_buffer_top uut (
        .clk(clk), .rst(rst),
        .victim_valid_i(victim_valid), .victim_addr_i(victim_addr),
        .victim_line_i(victim_line), .full_o(full), .empty_o(empty),
        .lk_valid_i(lk_valid), .lk_addr_i(lk_addr), .lk_we_i(lk_we),
        .lk_sel_i(lk_sel), .lk_wdata_i(lk_wdata),
        .lk_hit_o(lk_hit), .lk_rdata_o(lk_rdata),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack)
    );

    wb_mem_model mem (
        .clk(clk), .rst(rst), .stall_i(stall),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat), .wb_sel_i(wb_sel), .wb_ack_o(wb_ack)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] v;
        for (int i = 0; i < LINE_W; i++) begin
            v[i] = take_bit();
        end
        return v;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("[FAIL] %0t %s", $time, msg);
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else flag_error(msg);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("PASS  %s", name);
        end else begin
            failed++;
            $display("FAIL  %s (%0d errors)", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // wait states, or a full stall while hold_ack is set.
    always @(negedge clk) stall = hold_ack || take_bit();

    property beat_held_until_ack;
        @(posedge clk) disable iff (rst) (wb_stb && !wb_ack) |=>
            (wb_cyc && wb_stb && wb_we && $stable(wb_adr) && $stable(wb_dat)
             && $stable(wb_sel));
    endproperty
    a_beat_held: assert property (beat_held_until_ack)
        else flag_error("wishbone beat changed before ack");
    a_cyc_stb: assert property (@(posedge clk) wb_cyc == wb_stb)
        else flag_error("cyc and stb differ");
    a_full_empty: assert property (@(posedge clk) disable iff (rst) !(full && empty))
        else flag_error("full and empty both high");

    task automatic push_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
        int t;
        t = 0;
        @(negedge clk);
        victim_valid = 1'b1;
        victim_addr  = addr;
        victim_line  = line;
        while (full) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) abort_on_timeout("victim acceptance");
        end
        @(negedge clk); // accepted at the edge in between.
        victim_valid = 1'b0;
        sb_addr.push_back(addr);
        sb_line.push_back(line);
    endtask

    task automatic wait_busy();
        int t;
        t = 0;
        while (!uut.drain_busy) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) abort_on_timeout("drain start");
        end
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (!(empty && !uut.drain_busy)) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) abort_on_timeout("buffer to drain");
        end
    endtask

    // expected lookup result where the newest match wins.
    task automatic model_lookup(input logic [ADDR_W-1:0] addr, output logic hit,
                                output logic [WB_DAT_W-1:0] word);
        hit  = 1'b0;
        word = '0;
        for (int i = 0; i < sb_addr.size(); i++) begin
            if (!(i == 0 && inflight) && sb_addr[i][31:5] == addr[31:5]) begin
                hit  = 1'b1;
                word = sb_line[i][addr[4:2]*32 +: 32];
            end
        end
    endtask

    task automatic model_store(input logic [ADDR_W-1:0] addr, input logic [3:0] sel,
                               input logic [31:0] data);
        logic [LINE_W-1:0] tmp;
        for (int i = 0; i < sb_addr.size(); i++) begin
            if (!(i == 0 && inflight) && sb_addr[i][31:5] == addr[31:5]) begin
                tmp = sb_line[i];
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) tmp[addr[4:2]*32 + b*8 +: 8] = data[b*8 +: 8];
                end
                sb_line[i] = tmp;
            end
        end
    endtask

    task automatic lookup_check(input logic [ADDR_W-1:0] addr, input logic we,
                                input logic [3:0] sel, input logic [31:0] data);
        logic exp_hit;
        logic [31:0] exp_word;
        model_lookup(addr, exp_hit, exp_word);
        @(negedge clk);
        lk_valid = 1'b1;
        lk_we    = we;
        lk_addr  = addr;
        lk_sel   = sel;
        lk_wdata = data;
        #10;
        check(lk_hit == exp_hit, $sformatf("lookup %h hit %b", addr, lk_hit));
        check(lk_rdata == exp_word, $sformatf("lookup %h data %h exp %h", addr,
                                              lk_rdata, exp_word));
        @(negedge clk); // store merged at the edge in between.
        lk_valid = 1'b0;
        lk_we    = 1'b0;
        if (we) model_store(addr, sel, data);
    endtask

    // drains, checks write order and builds the expected image.
    task automatic settle(input logic check_counts);
        logic [ADDR_W-1:0] waddr;
        wait_drained();
        for (int i = 0; i < sb_addr.size(); i++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                waddr = {sb_addr[i][31:5], 3'(w), 2'b00};
                exp_mem[waddr[11:2]] = sb_line[i][w*32 +: 32];
                check(mem.wr_log.size() > 0, "missing wishbone write");
                if (mem.wr_log.size() > 0) begin
                    check(mem.wr_log.pop_front() == waddr,
                          $sformatf("write order wrong at %h", waddr));
                end
                if (check_counts) begin
                    check(mem.write_count[waddr[11:2]] == 1,
                          $sformatf("write count at %h", waddr));
                end
            end
        end
        check(mem.wr_log.size() == 0, "extra wishbone writes");
        for (int i = 0; i < sb_addr.size(); i++) compare_line(sb_addr[i]);
        sb_addr.delete();
        sb_line.delete();
        inflight = 1'b0;
    endtask

    task automatic compare_line(input logic [ADDR_W-1:0] addr);
        logic [9:0] idx;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            idx = {addr[11:5], 3'(w)};
            check(mem.mem_words[idx] == exp_mem[idx],
                  $sformatf("memory word %0d = %h exp %h", idx, mem.mem_words[idx],
                            exp_mem[idx]));
        end
    endtask

    initial begin
        rst = 1'b1;
        hold_ack = 1'b0;
        stall = 1'b0;
        inflight = 1'b0;
        victim_valid = 1'b0;
        victim_addr = '0;
        victim_line = '0;
        lk_valid = 1'b0;
        lk_we = 1'b0;
        lk_addr = '0;
        lk_sel = '0;
        lk_wdata = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check(empty && !full && !wb_cyc && !lk_hit, "outputs wrong after reset");
        end_test("reset");

        for (int k = 0; k < 3; k++) push_line(32'h20 * k, random_line());
        settle(1'b1);
        end_test("fifo drain");

        hold_ack = 1'b1; // head stays in flight.
        push_line(32'h100, random_line());
        wait_busy();
        inflight = 1'b1;
        push_line(32'h120, random_line());
        push_line(32'h120, random_line()); // newer copy of the same line.
        lookup_check(32'h12c, 1'b0, 4'h0, 32'h0);
        lookup_check(32'h300, 1'b0, 4'h0, 32'h0);
        end_test("lookup");

        lookup_check(32'h104, 1'b0, 4'h0, 32'h0);
        lookup_check(32'h104, 1'b1, 4'hf, 32'hdead_beef);
        end_test("in-flight lookup");

        lookup_check(32'h128, 1'b1, 4'b0101, 32'h1122_3344);
        lookup_check(32'h128, 1'b0, 4'h0, 32'h0); // reads back the merge.
        end_test("store merge lookup");

        push_line(32'h140, random_line());
        check(full, "full not raised at depth");
        fork
            begin
                repeat (4) @(negedge clk);
                check(full && victim_valid, "extra victim taken while full");
                hold_ack = 1'b0;
            end
            push_line(32'h160, random_line());
        join
        settle(1'b0);
        end_test("full and drain order");

        $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_write_buffer

//--- sim/wb_mem_model.sv
module wb_mem_model
    import cache_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                stall_i, // holds off ack while high.
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [ADDR_W-1:0]   wb_adr_i,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    input  logic [WB_SEL_W-1:0] wb_sel_i,
    output logic                wb_ack_o
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int MEM_WORDS = 1024; // 4 KiB window.

    logic [WB_DAT_W-1:0] mem_words [MEM_WORDS];
    int                  write_count [MEM_WORDS];
    logic [ADDR_W-1:0]   wr_log [$];  // byte addresses in write order.
    logic [9:0]          idx;

    assign idx = wb_adr_i[11:2];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_words[i]   <= ~(32'(i) << 2); // inverted byte address.
                write_count[i] <= 0;
            end
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0; // single-cycle ack.
        end else if (wb_cyc_i && wb_stb_i && wb_we_i && !stall_i) begin
            wb_ack_o <= 1'b1;
            for (int b = 0; b < WB_SEL_W; b++) begin
                if (wb_sel_i[b]) begin
                    mem_words[idx][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
                end
            end
            write_count[idx] <= write_count[idx] + 1;
            wr_log.push_back(wb_adr_i);
        end
    end

endmodule : wb_mem_model

//--- src/write_buffer_top.sv
module write_buffer_top
    import cache_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // victim input.
    input  logic                victim_valid_i,
    input  logic [ADDR_W-1:0]   victim_addr_i,
    input  logic [LINE_W-1:0]   victim_line_i,
    output logic                full_o,
    output logic                empty_o,

    // core lookup port.
    input  logic                lk_valid_i,
    input  logic [ADDR_W-1:0]   lk_addr_i,
    input  logic                lk_we_i,
    input  logic [WB_SEL_W-1:0] lk_sel_i,
    input  logic [WB_DAT_W-1:0] lk_wdata_i,
    output logic                lk_hit_o,
    output logic [WB_DAT_W-1:0] lk_rdata_o,

    // memory side.
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [ADDR_W-1:0]   wb_adr_o,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic [WB_SEL_W-1:0] wb_sel_o,
    input  logic                wb_ack_i
);

    logic                  tag_check;
    logic [TAG_W-1:0]      tag;
    logic [WORD_SEL_W-1:0] word_idx;
    logic [LINE_BYTES-1:0] line_mask;
    logic [LINE_W-1:0]     line_wdata;
    logic                  hit;
    logic [LINE_W-1:0]     hit_line;
    logic                  write_en;
    logic [LINE_W-1:0]     replace_line;
    logic [LINE_W-1:0]     head_line;
    logic [ADDR_W-1:0]     head_addr;
    logic                  yumi;
    logic                  drain_busy;

    lookup_decode u_decode (
        .lk_valid_i   (lk_valid_i),
        .lk_we_i      (lk_we_i),
        .lk_addr_i    (lk_addr_i),
        .lk_sel_i     (lk_sel_i),
        .lk_wdata_i   (lk_wdata_i),
        .tag_check_o  (tag_check),
        .tag_o        (tag),
        .word_idx_o   (word_idx),
        .line_mask_o  (line_mask),
        .line_wdata_o (line_wdata)
    );

    evict_buffer u_buffer (
        .clk            (clk),
        .rst            (rst),
        .victim_valid_i (victim_valid_i),
        .victim_addr_i  (victim_addr_i),
        .victim_line_i  (victim_line_i),
        .full_o         (full_o),
        .empty_o        (empty_o),
        .tag_check_i    (tag_check),
        .tag_i          (tag),
        .hit_o          (hit),
        .hit_line_o     (hit_line),
        .write_en_i     (write_en),
        .replace_line_i (replace_line),
        .head_line_o    (head_line),
        .head_addr_o    (head_addr),
        .yumi_i         (yumi),
        .drain_busy_i   (drain_busy)
    );

    lookup_result u_result (
        .word_idx_i     (word_idx),
        .line_mask_i    (line_mask),
        .line_wdata_i   (line_wdata),
        .hit_i          (hit),
        .hit_line_i     (hit_line),
        .lk_hit_o       (lk_hit_o),
        .lk_rdata_o     (lk_rdata_o),
        .write_en_o     (write_en),
        .replace_line_o (replace_line)
    );

    line_drain u_drain (
        .clk          (clk),
        .rst          (rst),
        .empty_i      (empty_o), // same flag the cache sees.
        .head_line_i  (head_line),
        .head_addr_i  (head_addr),
        .yumi_o       (yumi),
        .drain_busy_o (drain_busy),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_o     (wb_dat_o),
        .wb_sel_o     (wb_sel_o),
        .wb_ack_i     (wb_ack_i)
    );

endmodule : write_buffer_top

//--- src/line_drain.sv
module line_drain
    import cache_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                empty_i,
    input  logic [LINE_W-1:0]   head_line_i,
    input  logic [ADDR_W-1:0]   head_addr_i,
    output logic                yumi_o,
    output logic                drain_busy_o,

    // wishbone classic master, writes only.
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [ADDR_W-1:0]   wb_adr_o,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic [WB_SEL_W-1:0] wb_sel_o,
    input  logic                wb_ack_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_strobe, // beat on the bus, waiting for ack.
        st_gap     // one idle cycle after each ack.
    } drain_state_t;

    drain_state_t      state;
    logic [BEAT_W-1:0] beat;
    logic              last_beat;
    logic              line_done; // eighth ack seen.

    assign last_beat = (beat == BEAT_W'(WORDS_PER_LINE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            beat      <= '0;
            line_done <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (!empty_i) begin
                        state <= st_strobe;
                    end
                end
                st_strobe: begin
                    if (wb_ack_i) begin
                        beat      <= beat + BEAT_W'(1);
                        line_done <= last_beat;
                        state     <= st_gap;
                    end
                end
                st_gap: begin
                    if (line_done) begin
                        beat      <= '0;
                        line_done <= 1'b0;
                        state     <= st_idle; // head retires at this edge.
                    end else begin
                        state <= st_strobe;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign yumi_o       = (state == st_gap) && line_done;
    assign drain_busy_o = (state != st_idle);

    // head entry is frozen while busy, so these hold until ack.
    assign wb_cyc_o = (state == st_strobe);
    assign wb_stb_o = (state == st_strobe);
    assign wb_we_o  = (state == st_strobe);
    assign wb_adr_o = {head_addr_i[ADDR_W-1:OFFSET_W], beat, 2'b00};
    assign wb_dat_o = head_line_i[beat*WB_DAT_W +: WB_DAT_W];
    assign wb_sel_o = '1;

endmodule : line_drain

//--- src/lookup_result.sv
module lookup_result
    import cache_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic [WORD_SEL_W-1:0] word_idx_i,
    input  logic [LINE_BYTES-1:0] line_mask_i,
    input  logic [LINE_W-1:0]     line_wdata_i,
    input  logic                  hit_i,
    input  logic [LINE_W-1:0]     hit_line_i,
    output logic                  lk_hit_o,
    output logic [WB_DAT_W-1:0]   lk_rdata_o,
    output logic                  write_en_o,
    output logic [LINE_W-1:0]     replace_line_o
);

    logic [WB_DAT_W-1:0] sel_word; // addressed word of the hit line.

    assign sel_word   = hit_line_i[word_idx_i*WB_DAT_W +: WB_DAT_W];
    assign lk_hit_o   = hit_i;
    assign lk_rdata_o = hit_i ? sel_word : '0; // zero on a miss.

    // only a store that hits touches the buffer.
    assign write_en_o = hit_i && (|line_mask_i);

    // byte merge of store data over the hit line.
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (line_mask_i[b]) begin
                replace_line_o[b*8 +: 8] = line_wdata_i[b*8 +: 8];
            end else begin
                replace_line_o[b*8 +: 8] = hit_line_i[b*8 +: 8];
            end
        end
    end

endmodule : lookup_result

//--- src/evict_buffer.sv
module evict_buffer
    import cache_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // victim lines from the cache, valid/full handshake.
    input  logic              victim_valid_i,
    input  logic [ADDR_W-1:0] victim_addr_i,
    input  logic [LINE_W-1:0] victim_line_i,
    output logic              full_o,
    output logic              empty_o,

    // associative search and merge.
    input  logic              tag_check_i,
    input  logic [TAG_W-1:0]  tag_i,
    output logic              hit_o,
    output logic [LINE_W-1:0] hit_line_o,
    input  logic              write_en_i,
    input  logic [LINE_W-1:0] replace_line_i,

    // head entry to the drain, valid/yumi handshake.
    output logic [LINE_W-1:0] head_line_o,
    output logic [ADDR_W-1:0] head_addr_o,
    input  logic              yumi_i,
    input  logic              drain_busy_i
);

    logic [LINE_W-1:0]    queue_data [EWB_DEPTH];
    logic [ADDR_W-1:0]    queue_addr [EWB_DEPTH];

    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [CNT_W-1:0]     count;
    logic                 enqueue;
    logic                 dequeue;
    logic [EWB_DEPTH-1:0] match; // indexed by physical slot.

    assign full_o  = (count == CNT_W'(EWB_DEPTH));
    assign empty_o = (count == '0);
    assign enqueue = victim_valid_i && !full_o;
    assign dequeue = yumi_i && !empty_o;

    // pointers and occupancy.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (dequeue) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({enqueue, dequeue})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: ; // both or neither, count holds.
            endcase
        end
    end

    // line storage. the enqueue slot is free, so it never collides with a merge.
    always_ff @(posedge clk) begin
        if (enqueue) begin
            queue_data[wr_ptr] <= victim_line_i;
            queue_addr[wr_ptr] <= victim_addr_i;
        end
        for (int s = 0; s < EWB_DEPTH; s++) begin
            if (write_en_i && match[s]) begin
                queue_data[s] <= replace_line_i;
            end
        end
    end

    // oldest to newest, so the last match left standing is the newest.
    always_comb begin
        logic [PTR_W-1:0] slot;
        logic             live;
        match      = '0;
        hit_o      = 1'b0;
        hit_line_o = '0;
        for (int i = 0; i < EWB_DEPTH; i++) begin
            slot = rd_ptr + PTR_W'(i);
            live = (CNT_W'(i) < count) && !((i == 0) && drain_busy_i); // head in flight.
            if (tag_check_i && live && (queue_addr[slot][ADDR_W-1:OFFSET_W] == tag_i)) begin
                match[slot] = 1'b1;
                hit_o       = 1'b1;
                hit_line_o  = queue_data[slot];
            end
        end
    end

    assign head_line_o = queue_data[rd_ptr];
    assign head_addr_o = queue_addr[rd_ptr];

endmodule : evict_buffer

//--- src/lookup_decode.sv
module lookup_decode
    import cache_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic                  lk_valid_i,
    input  logic                  lk_we_i,
    input  logic [ADDR_W-1:0]     lk_addr_i,
    input  logic [WB_SEL_W-1:0]   lk_sel_i,
    input  logic [WB_DAT_W-1:0]   lk_wdata_i,
    output logic                  tag_check_o,
    output logic [TAG_W-1:0]      tag_o,
    output logic [WORD_SEL_W-1:0] word_idx_o,
    output logic [LINE_BYTES-1:0] line_mask_o,
    output logic [LINE_W-1:0]     line_wdata_o
);

    logic store; // a write lookup, mask may be non-zero.

    assign store       = lk_valid_i && lk_we_i;
    assign tag_check_o = lk_valid_i;
    assign tag_o       = lk_addr_i[ADDR_W-1:OFFSET_W];
    assign word_idx_o  = lk_addr_i[OFFSET_W-1:2];

    // store word copied into every word slot; the mask picks the real one.
    assign line_wdata_o = {WORDS_PER_LINE{lk_wdata_i}};

    // byte selects moved to the addressed word.
    always_comb begin
        line_mask_o = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (store && (word_idx_o == WORD_SEL_W'(w))) begin
                line_mask_o[w*WB_SEL_W +: WB_SEL_W] = lk_sel_i;
            end
        end
    end

endmodule : lookup_decode

//--- src/wb_bus_pkg.sv
package wb_bus_pkg;

    // wishbone classic data path.
    localparam int unsigned WB_DAT_W = 32;
    localparam int unsigned WB_SEL_W = 4;  // one select per byte.

    // a line leaves the buffer as this many single writes.
    localparam int unsigned WORDS_PER_LINE = 8;
    localparam int unsigned BEAT_W         = 3; // beat counter width.

endpackage : wb_bus_pkg

//--- src/cache_types_pkg.sv
package cache_types_pkg;

    // cache line geometry.
    localparam int unsigned LINE_W     = 256; // bits per victim line.
    localparam int unsigned LINE_BYTES = 32;  // one mask bit per byte.

    // byte address split of a 32-bit RV32I address.
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned OFFSET_W   = 5;   // byte offset in line.
    localparam int unsigned WORD_SEL_W = 3;   // addr[4:2].
    localparam int unsigned TAG_W      = 27;  // addr[31:5], the line address.

    // eviction buffer sizing.
    // kept at four entries so that the full state is easy to reach.
    localparam int unsigned EWB_DEPTH  = 4;
    localparam int unsigned PTR_W      = 2;   // wraps naturally at depth 4.
    localparam int unsigned CNT_W      = 3;   // counts 0 to EWB_DEPTH.

endpackage : cache_types_pkg
